/* rtl/llc_tag_settings.svh */
// Tag store geometry; LLC_WAYS must be a power of two and at least 2, LLC_RAM_LATENCY at least 1
`ifndef LLC_TAG_SETTINGS_SVH
`define LLC_TAG_SETTINGS_SVH

// Number of ways, one tag macro each
`define LLC_WAYS 4

// Set index width, gives 16 sets
`define LLC_INDEX_W 4

// Stored tag width in bits
`define LLC_TAG_W 10

// Tag macro read latency in cycles
`define LLC_RAM_LATENCY 1

`endif

/* rtl/llc_tag_types_pkg.sv */
// Vector and entry types of the tag store; widths follow the macros in llc_tag_settings.svh
`include "llc_tag_settings.svh"

package llc_tag_types_pkg;

  // Tag as stored in a macro or carried by a request
  typedef logic [`LLC_TAG_W-1:0] tag_t;

  // Set index, also the macro address
  typedef logic [`LLC_INDEX_W-1:0] index_t;

  // One bit per way, used both one-hot and as a mask
  typedef logic [`LLC_WAYS-1:0] way_ind_t;

  // Binary way number
  typedef logic [$clog2(`LLC_WAYS)-1:0] way_bin_t;

  // One macro word
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

endpackage

/* rtl/llc_tag_ctrl_pkg.sv */
// Request mode and controller state encodings; only lookup and flush requests exist
package llc_tag_ctrl_pkg;

  // Request mode
  typedef enum logic {
    LOOKUP = 1'b0,
    FLUSH  = 1'b1
  } store_mode_e;

  // Controller state, one request in flight at a time
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    READ = 2'd1,
    RESP = 2'd2
  } ctrl_state_e;

endpackage

/* rtl/tag_ram_if.sv */
// Tag macro access bundle; index and write data are shared by all ways, req and we are per way
`include "llc_tag_settings.svh"

interface tag_ram_if;
  import llc_tag_types_pkg::*;

  // Per-way access request and write enable
  way_ind_t req;
  way_ind_t we;
  // Common address and write data
  index_t index;
  tag_entry_t wdata;
  // Read data of every way
  tag_entry_t [`LLC_WAYS-1:0] rdata;
  // Read data became valid
  way_ind_t rvalid;

  // Controller side
  modport ctrl (
    output req, we, index, wdata,
    input  rvalid
  );

  // Memory side
  modport bank (
    input  req, we, index, wdata,
    output rdata, rvalid
  );

  // Comparator side
  modport match (
    input rdata
  );

endinterface

/* rtl/tag_way_banks.sv */
// One tag memory per way; contents clear on reset, read data holds until the next read arrives
`include "llc_tag_settings.svh"

module tag_way_banks (
  input logic       clk_i,
  input logic       rst_n_i,
  tag_ram_if.bank   ram
);
  import llc_tag_types_pkg::*;

  localparam int unsigned WAYS = `LLC_WAYS;
  localparam int unsigned SETS = 1 << `LLC_INDEX_W;
  localparam int unsigned LAT  = `LLC_RAM_LATENCY;

  for (genvar w = 0; w < WAYS; w++) begin : gen_way
    // Storage for this way
    tag_entry_t mem_q [SETS];
    // Read data stages, each one loads only when a token passes
    tag_entry_t [LAT-1:0] pipe_q;
    // Read-valid token per stage
    logic [LAT-1:0] tok_q;
    logic rd;
    logic wr;

    assign rd = ram.req[w] & ~ram.we[w];
    assign wr = ram.req[w] & ram.we[w];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        mem_q  <= '{default: '0};
        pipe_q <= '0;
        tok_q  <= '0;
      end else begin
        if (wr) begin
          mem_q[ram.index] <= ram.wdata;
        end
        // First stage samples the array
        if (rd) begin
          pipe_q[0] <= mem_q[ram.index];
        end
        tok_q[0] <= rd;
        // Later stages follow the token
        for (int s = 1; s < LAT; s++) begin
          tok_q[s] <= tok_q[s-1];
          if (tok_q[s-1]) begin
            pipe_q[s] <= pipe_q[s-1];
          end
        end
      end
    end

    assign ram.rdata[w]  = pipe_q[LAT-1];
    assign ram.rvalid[w] = tok_q[LAT-1];
  end

endmodule

/* rtl/tag_match.sv */
// Combinational compare of the read set; outputs are zero unless a way is selected
module tag_match (
  tag_ram_if.match                     ram,
  input  llc_tag_ctrl_pkg::store_mode_e mode_i,
  input  llc_tag_types_pkg::tag_t      tag_i,
  input  llc_tag_types_pkg::way_ind_t  allowed_i,
  input  llc_tag_types_pkg::way_ind_t  victim_way_i,
  output logic                         any_hit_o,
  output logic                         hit_dirty_o,
  output llc_tag_types_pkg::way_ind_t  res_way_o,
  output logic                         res_hit_o,
  output logic                         res_evict_o,
  output llc_tag_types_pkg::tag_t      res_evict_tag_o
);
  import llc_tag_types_pkg::*;
  import llc_tag_ctrl_pkg::*;

  localparam int unsigned WAYS = $bits(way_ind_t);

  way_ind_t   hit;
  way_bin_t   sel_bin;
  tag_entry_t sel;
  logic       sel_ok;

  // Hit needs a valid entry, equal tag and an allowed way
  always_comb begin
    hit = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit[w] = (mode_i == LOOKUP) && allowed_i[w] && ram.rdata[w].valid &&
               (ram.rdata[w].tag == tag_i);
    end
  end

  assign any_hit_o = |hit;

  // Way named in the response
  always_comb begin
    if (mode_i == FLUSH) begin
      res_way_o = allowed_i;
    end else if (any_hit_o) begin
      res_way_o = hit;
    end else begin
      res_way_o = victim_way_i;
    end
  end

  // One-hot to binary, by OR of the set positions
  always_comb begin
    sel_bin = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (res_way_o[w]) begin
        sel_bin = sel_bin | way_bin_t'(w);
      end
    end
  end

  assign sel    = ram.rdata[sel_bin];
  assign sel_ok = |res_way_o;

  assign hit_dirty_o = any_hit_o & sel.dirty;
  assign res_hit_o   = any_hit_o;

  // A dirty line leaves only on a miss or a flush
  assign res_evict_o     = sel_ok & ~any_hit_o & sel.valid & sel.dirty;
  assign res_evict_tag_o = (sel_ok && !any_hit_o) ? sel.tag : '0;

endmodule

/* rtl/victim_select.sv */
// Victim choice among allowed ways; invalid ways go first, then round robin from the pointer
module victim_select (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        ctrl_clr_i,
  input  logic                        pick_i,
  input  llc_tag_types_pkg::way_ind_t valid_i,
  input  llc_tag_types_pkg::way_ind_t allowed_i,
  output llc_tag_types_pkg::way_ind_t victim_way_o
);
  import llc_tag_types_pkg::*;

  localparam int unsigned WAYS = $bits(way_ind_t);

  way_bin_t rr_q;
  way_ind_t free;
  way_ind_t free_first;
  logic     rr_found;
  way_bin_t rr_bin;
  way_bin_t cand;

  // Allowed ways that hold nothing
  assign free       = allowed_i & ~valid_i;
  assign free_first = free & way_ind_t'(~free + way_ind_t'(1));

  // First allowed way at or after the pointer, wrapping
  always_comb begin
    rr_found = 1'b0;
    rr_bin   = '0;
    cand     = '0;
    for (int i = 0; i < WAYS; i++) begin
      cand = rr_q + way_bin_t'(i);
      if (!rr_found && allowed_i[cand]) begin
        rr_found = 1'b1;
        rr_bin   = cand;
      end
    end
  end

  always_comb begin
    if (|free) begin
      victim_way_o = free_first;
    end else if (rr_found) begin
      victim_way_o = way_ind_t'(1) << rr_bin;
    end else begin
      // Nothing allowed
      victim_way_o = '0;
    end
  end

  // Pointer only moves when a valid line was replaced
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (ctrl_clr_i) begin
      rr_q <= '0;
    end else if (pick_i && !(|free) && rr_found) begin
      rr_q <= rr_bin + way_bin_t'(1);
    end
  end

endmodule

/* rtl/tag_lookup_ctrl.sv */
// Request FSM with one request in flight; write-back happens on the edge that consumes the response
module tag_lookup_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  llc_tag_ctrl_pkg::store_mode_e req_mode_i,
  input  llc_tag_types_pkg::index_t     req_index_i,
  input  llc_tag_types_pkg::tag_t       req_tag_i,
  input  logic                          req_dirty_i,
  input  llc_tag_types_pkg::way_ind_t   req_way_i,
  output logic                          res_valid_o,
  input  logic                          res_ready_i,
  input  llc_tag_types_pkg::way_ind_t   spm_lock_i,
  input  logic                          any_hit_i,
  input  logic                          hit_dirty_i,
  input  llc_tag_types_pkg::way_ind_t   res_way_i,
  tag_ram_if.ctrl                       ram,
  output llc_tag_ctrl_pkg::store_mode_e mode_o,
  output llc_tag_types_pkg::tag_t       tag_o,
  output llc_tag_types_pkg::way_ind_t   allowed_o,
  output logic                          pick_o
);
  import llc_tag_types_pkg::*;
  import llc_tag_ctrl_pkg::*;

  ctrl_state_e state_q, state_d;
  store_mode_e mode_q;
  way_ind_t    allowed_q;
  tag_t        tag_q;
  index_t      index_q;
  logic        dirty_q;
  logic        accept;
  logic        consume;

  assign req_ready_o = (state_q == IDLE);
  assign res_valid_o = (state_q == RESP);
  assign accept      = req_valid_i & req_ready_o;
  assign consume     = res_valid_o & res_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: if (accept) state_d = READ;
      // Wait for the macro read
      READ: if (|ram.rvalid) state_d = RESP;
      RESP: if (consume) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Macro control
  always_comb begin
    ram.req   = '0;
    ram.we    = '0;
    ram.index = index_q;
    ram.wdata = '0;
    pick_o    = 1'b0;
    if (accept) begin
      // Read the set on every way
      ram.req   = '1;
      ram.index = req_index_i;
    end else if (consume) begin
      if (mode_q == FLUSH) begin
        // Invalidate the flushed way
        ram.req = allowed_q;
        ram.we  = allowed_q;
      end else if (any_hit_i) begin
        // Mark a clean hit dirty
        if (dirty_q && !hit_dirty_i) begin
          ram.req   = res_way_i;
          ram.we    = res_way_i;
          ram.wdata = '{valid: 1'b1, dirty: 1'b1, tag: tag_q};
        end
      end else if (|res_way_i) begin
        // Miss refills the victim
        ram.req   = res_way_i;
        ram.we    = res_way_i;
        ram.wdata = '{valid: 1'b1, dirty: dirty_q, tag: tag_q};
        pick_o    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      mode_q    <= LOOKUP;
      allowed_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        mode_q    <= req_mode_i;
        // Locked ways drop out of lookups only
        allowed_q <= (req_mode_i == FLUSH) ? req_way_i : (req_way_i & ~spm_lock_i);
      end
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q   <= req_tag_i;
      index_q <= req_index_i;
      dirty_q <= req_dirty_i;
    end
  end

  assign mode_o    = mode_q;
  assign tag_o     = tag_q;
  assign allowed_o = allowed_q;

endmodule

/* rtl/llc_tag_store.sv */
// LLC tag store top; one request at a time, res_way_o is one-hot and zero when no way is usable
module llc_tag_store (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Request
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  llc_tag_ctrl_pkg::store_mode_e req_mode_i,
  input  llc_tag_types_pkg::index_t     req_index_i,
  input  llc_tag_types_pkg::tag_t       req_tag_i,
  input  logic                          req_dirty_i,
  input  llc_tag_types_pkg::way_ind_t   req_way_i,
  // Response
  output logic                          res_valid_o,
  input  logic                          res_ready_i,
  output llc_tag_types_pkg::way_ind_t   res_way_o,
  output logic                          res_hit_o,
  output logic                          res_evict_o,
  output llc_tag_types_pkg::tag_t       res_evict_tag_o,
  // Configuration
  input  llc_tag_types_pkg::way_ind_t   spm_lock_i,
  input  logic                          ctrl_clr_i
);
  import llc_tag_types_pkg::*;
  import llc_tag_ctrl_pkg::*;

  tag_ram_if ram ();

  store_mode_e mode;
  tag_t        tag;
  way_ind_t    allowed;
  way_ind_t    victim_way;
  way_ind_t    valid_vec;
  logic        pick;
  logic        any_hit;
  logic        hit_dirty;

  // Valid bits of the read set feed the victim choice
  for (genvar w = 0; w < $bits(way_ind_t); w++) begin : gen_valid
    assign valid_vec[w] = ram.rdata[w].valid;
  end

  tag_lookup_ctrl u_ctrl (
    .clk_i, .rst_n_i,
    .req_valid_i, .req_ready_o, .req_mode_i, .req_index_i,
    .req_tag_i, .req_dirty_i, .req_way_i,
    .res_valid_o, .res_ready_i, .spm_lock_i,
    .any_hit_i   (any_hit),
    .hit_dirty_i (hit_dirty),
    .res_way_i   (res_way_o),
    .ram         (ram.ctrl),
    .mode_o      (mode),
    .tag_o       (tag),
    .allowed_o   (allowed),
    .pick_o      (pick)
  );

  tag_way_banks u_banks (.clk_i, .rst_n_i, .ram(ram.bank));

  tag_match u_match (
    .ram (ram.match), .mode_i (mode), .tag_i (tag),
    .allowed_i (allowed), .victim_way_i (victim_way),
    .any_hit_o (any_hit), .hit_dirty_o (hit_dirty),
    .res_way_o, .res_hit_o, .res_evict_o, .res_evict_tag_o
  );

  victim_select u_victim (
    .clk_i, .rst_n_i, .ctrl_clr_i,
    .pick_i (pick), .valid_i (valid_vec), .allowed_i (allowed),
    .victim_way_o (victim_way)
  );

endmodule

/* verification/tb_llc_tag_store.sv */
// Tag store testbench; sets 0 to 7 take directed requests, sets 8 to 15 take random full-mask traffic
`include "llc_tag_settings.svh"

module tb_llc_tag_store;
  timeunit 1ns;
  timeprecision 100ps;
  import llc_tag_types_pkg::*;
  import llc_tag_ctrl_pkg::*;

  localparam int SETS = 1 << `LLC_INDEX_W;
  localparam int WAYS = `LLC_WAYS;
  localparam int TIMEOUT_CYCLES = 4000;

  logic clk_i, rst_n_i, req_valid_i, req_ready_o, req_dirty_i, res_valid_o, res_ready_i;
  logic res_hit_o, res_evict_o, ctrl_clr_i;
  store_mode_e req_mode_i;
  index_t req_index_i;
  tag_t req_tag_i, res_evict_tag_o;
  way_ind_t req_way_i, res_way_o, spm_lock_i;

  // Reference store and round-robin pointer
  logic m_valid [SETS][WAYS];
  logic m_dirty [SETS][WAYS];
  tag_t m_tag [SETS][WAYS];
  int m_rr;
  // Expected response of the request in flight
  way_ind_t exp_way;
  logic exp_hit, exp_evict;
  tag_t exp_evict_tag;
  int p_vic, p_hit_w;
  bit p_rr_move;
  string test_name;
  int unsigned cycle_cnt;
  logic accept_w, consume_w;

  assign accept_w  = req_valid_i & req_ready_o;
  assign consume_w = res_valid_o & res_ready_i;

  llc_tag_store dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt == TIMEOUT_CYCLES);
    $display("Timeout: no end of test after %0d clock cycles in %s", TIMEOUT_CYCLES, test_name);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  task automatic report_mismatch(input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[ERROR] %s: %s expected %0h actual %0h", test_name, field, exp, act);
    $display("Simulation failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("%s: %s", test_name, what);
    $display("Simulation failed");
    $fatal(1, "protocol failure");
  endtask

  // Handshake and latency
  a_reset: assert property (@(posedge clk_i) !$past(rst_n_i) |-> req_ready_o && !res_valid_o)
    else report_failure("ready or valid wrong out of reset");
  a_read_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(accept_w) |-> !res_valid_o && !req_ready_o)
    else report_failure("response or ready too early after acceptance");
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(accept_w, 2) |-> res_valid_o)
    else report_failure("response not valid one cycle after the read");
  a_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i) res_valid_o |-> !req_ready_o)
    else report_failure("request ready while a response is pending");
  a_ready_again: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(consume_w) |-> req_ready_o && !res_valid_o)
    else report_failure("not ready in the cycle after consumption");
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(res_valid_o && !res_ready_i) |-> res_valid_o && $stable(res_way_o) &&
    $stable(res_hit_o) && $stable(res_evict_o) && $stable(res_evict_tag_o))
    else report_failure("response dropped or changed under back-pressure");

  // Payload against the reference model
  a_way: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o |-> res_way_o == exp_way)
    else report_mismatch("way", 32'(exp_way), 32'($sampled(res_way_o)));
  a_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o |-> res_hit_o == exp_hit)
    else report_mismatch("hit", 32'(exp_hit), 32'($sampled(res_hit_o)));
  a_evict: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o |-> res_evict_o == exp_evict)
    else report_mismatch("evict", 32'(exp_evict), 32'($sampled(res_evict_o)));
  a_evict_tag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o |-> res_evict_tag_o == exp_evict_tag)
    else report_mismatch("evict tag", 32'(exp_evict_tag), 32'($sampled(res_evict_tag_o)));

  // Inputs move half a nanosecond after the edge
  task automatic step();
    @(posedge clk_i);
    #0.5;
  endtask

  // Expected response from the model state before the request
  task automatic predict(input store_mode_e mode, input int idx, input tag_t tag,
                         input way_ind_t way);
    way_ind_t allowed;
    int c;
    allowed = (mode == FLUSH) ? way : (way & ~spm_lock_i);
    exp_way = '0;
    exp_hit = 1'b0;
    exp_evict = 1'b0;
    exp_evict_tag = '0;
    p_vic = -1;
    p_hit_w = -1;
    p_rr_move = 1'b0;
    if (mode == FLUSH) begin
      for (int w = 0; w < WAYS; w++) if (way[w]) p_vic = w;
      exp_way = way;
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (allowed[w] && m_valid[idx][w] && m_tag[idx][w] == tag) p_hit_w = w;
      end
      if (p_hit_w >= 0) begin
        exp_hit = 1'b1;
        exp_way = way_ind_t'(1) << p_hit_w;
      end else begin
        // Lowest empty allowed way, else round robin from the pointer
        for (int w = 0; w < WAYS; w++) begin
          if (p_vic < 0 && allowed[w] && !m_valid[idx][w]) p_vic = w;
        end
        for (int i = 0; i < WAYS; i++) begin
          c = (m_rr + i) % WAYS;
          if (p_vic < 0 && allowed[c]) begin
            p_vic = c;
            p_rr_move = 1'b1;
          end
        end
        if (p_vic >= 0) exp_way = way_ind_t'(1) << p_vic;
      end
    end
    if (p_vic >= 0 && !exp_hit) begin
      exp_evict = m_valid[idx][p_vic] & m_dirty[idx][p_vic];
      exp_evict_tag = m_tag[idx][p_vic];
    end
  endtask

  // Model write-back at consumption
  task automatic update(input store_mode_e mode, input int idx, input tag_t tag,
                        input logic dirty);
    if (mode == FLUSH) begin
      if (p_vic >= 0) begin
        m_valid[idx][p_vic] = 1'b0;
        m_dirty[idx][p_vic] = 1'b0;
        m_tag[idx][p_vic] = '0;
      end
    end else if (p_hit_w >= 0) begin
      if (dirty) m_dirty[idx][p_hit_w] = 1'b1;
    end else if (p_vic >= 0) begin
      m_valid[idx][p_vic] = 1'b1;
      m_dirty[idx][p_vic] = dirty;
      m_tag[idx][p_vic] = tag;
      if (p_rr_move) m_rr = (p_vic + 1) % WAYS;
    end
  endtask

  task automatic do_request(input store_mode_e mode, input int idx, input tag_t tag,
                            input logic dirty, input way_ind_t way, input int bp);
    predict(mode, idx, tag, way);
    req_valid_i = 1'b1;
    req_mode_i = mode;
    req_index_i = index_t'(idx);
    req_tag_i = tag;
    req_dirty_i = dirty;
    req_way_i = way;
    while (!req_ready_o) step();
    step();
    req_valid_i = 1'b0;
    while (!res_valid_o) step();
    // Hold the response back for bp cycles
    repeat (bp) step();
    res_ready_i = 1'b1;
    step();
    res_ready_i = 1'b0;
    update(mode, idx, tag, dirty);
  endtask

  task automatic clear_pointer();
    ctrl_clr_i = 1'b1;
    step();
    ctrl_clr_i = 1'b0;
    m_rr = 0;
  endtask

  initial begin
    int idx;
    int bp;
    tag_t tg;
    void'($urandom(32'h37f80160));
    cycle_cnt = 0;
    test_name = "reset";
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_mode_i = LOOKUP;
    req_index_i = '0;
    req_tag_i = '0;
    req_dirty_i = 1'b0;
    req_way_i = '0;
    res_ready_i = 1'b0;
    spm_lock_i = '0;
    ctrl_clr_i = 1'b0;
    m_rr = 0;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w] = '0;
      end
    end
    repeat (10) @(posedge clk_i);
    #0.5;
    rst_n_i = 1'b1;
    step();

    test_name = "miss_hit";
    do_request(LOOKUP, 0, 10'h055, 1'b0, 4'b1111, 0);
    do_request(LOOKUP, 0, 10'h055, 1'b0, 4'b1111, 0);
    do_request(LOOKUP, 1, 10'h0a1, 1'b0, 4'b1100, 0);
    do_request(LOOKUP, 1, 10'h0a1, 1'b0, 4'b1100, 0);

    test_name = "dirty_flush";
    do_request(LOOKUP, 0, 10'h055, 1'b1, 4'b1111, 0);
    do_request(FLUSH, 0, '0, 1'b0, 4'b0001, 0);
    do_request(FLUSH, 0, '0, 1'b0, 4'b0001, 0);
    do_request(LOOKUP, 0, 10'h055, 1'b0, 4'b1111, 0);

    test_name = "replacement";
    for (int i = 0; i < 4; i++) do_request(LOOKUP, 2, tag_t'(10'h100 + i), 1'(i), 4'b1111, 0);
    for (int i = 0; i < 6; i++) do_request(LOOKUP, 2, tag_t'(10'h110 + i), 1'(i), 4'b1111, 0);
    clear_pointer();
    do_request(LOOKUP, 2, 10'h120, 1'b0, 4'b1111, 0);

    test_name = "spm_lock";
    for (int i = 0; i < 4; i++) do_request(LOOKUP, 3, tag_t'(10'h200 + i), 1'b1, 4'b1111, 0);
    spm_lock_i = 4'b0011;
    do_request(LOOKUP, 3, 10'h200, 1'b0, 4'b1111, 0);
    do_request(LOOKUP, 3, 10'h250, 1'b0, 4'b1111, 0);
    do_request(LOOKUP, 3, 10'h251, 1'b0, 4'b1111, 0);
    // Every requested way locked leaves the set alone
    do_request(LOOKUP, 3, 10'h201, 1'b1, 4'b0011, 0);
    spm_lock_i = '0;
    do_request(LOOKUP, 3, 10'h201, 1'b0, 4'b0010, 0);

    test_name = "backpressure";
    do_request(LOOKUP, 4, 10'h300, 1'b1, 4'b1111, 8);
    do_request(FLUSH, 4, '0, 1'b0, 4'b0001, 8);

    test_name = "random";
    for (int n = 0; n < 240; n++) begin
      idx = 8 + $urandom_range(7);
      tg = tag_t'(1 + $urandom_range(5));
      bp = $urandom_range(8);
      if (n % 60 == 59) clear_pointer();
      if ($urandom_range(4) == 0) begin
        do_request(FLUSH, idx, '0, 1'b0, way_ind_t'(1) << $urandom_range(3), bp);
      end else begin
        do_request(LOOKUP, idx, tg, 1'($urandom_range(1)), 4'b1111, bp);
      end
    end

    step();
    $display("Simulation passed");
    $finish;
  end

endmodule

/* llc_tag_store.f */
+incdir+rtl
rtl/llc_tag_types_pkg.sv
rtl/llc_tag_ctrl_pkg.sv
rtl/tag_ram_if.sv
rtl/tag_way_banks.sv
rtl/tag_match.sv
rtl/victim_select.sv
rtl/tag_lookup_ctrl.sv
rtl/llc_tag_store.sv
verification/tb_llc_tag_store.sv
